// ==== cdc_req_aggregator.sv ====
// CDC request aggregator: synchronizes async requests, merges all requests, returns clkack

`timescale 1ns/1ps

module cdc_req_aggregator #(
    parameter int ICDC            = 5,
    parameter int NGCLK_REQ_ASYNC = 5
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic [ICDC-1:0]            cdc_clkreq,
    input  logic [NGCLK_REQ_ASYNC-1:0] cdc_gclock_req_async,
    input  logic                       clk_on,
    output logic [ICDC-1:0]            cdc_clkack,
    output logic                       activity
);

    logic [NGCLK_REQ_ASYNC-1:0] async_meta;  // First synchronizer stage
    logic [NGCLK_REQ_ASYNC-1:0] async_sync;  // Second synchronizer stage
    logic                       sync_any;    // Any synchronous clkreq
    logic                       async_any;   // Any synchronized async request
    logic [ICDC-1:0]            ack_nxt;

    // Two-flop synchronizer on each async request bit
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            async_meta <= '0;
            async_sync <= '0;
        end else begin
            async_meta <= cdc_gclock_req_async;
            async_sync <= async_meta;
        end
    end

    assign sync_any  = |cdc_clkreq;
    assign async_any = |async_sync;

    // Registered request view for the controller
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            activity <= 1'b0;
        end else begin
            activity <= sync_any | async_any;
        end
    end

    // An agent only sees its ack while it still requests and the clock is running
    assign ack_nxt = cdc_clkreq & {ICDC{clk_on}};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cdc_clkack <= '0;
        end else begin
            cdc_clkack <= ack_nxt;  // Drops the cycle after clkreq falls
        end
    end

endmodule

// ==== pgcbcg.f ====
pgcbcg_pkg.sv
pgcbcg_cfg_regs.sv
cdc_req_aggregator.sv
pgcbcg_ctrl.sv
pgcbcg_top.sv
tb_pgcbcg.sv

// ==== pgcbcg_cfg_regs.sv ====
// Clock-gate configuration registers with single-cycle write and read strobes

`timescale 1ns/1ps

module pgcbcg_cfg_regs
    import pgcbcg_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      cfg_wr,
    input  logic      cfg_rd,
    input  cfg_addr_e cfg_addr,
    input  logic [7:0] cfg_wdata,
    output logic [7:0] cfg_rdata,
    output logic      cfg_rvalid,
    output cg_cfg_t   cfg
);

    cg_cfg_t    cfg_q;      // Register contents
    logic [7:0] rd_mux;     // Read data for the addressed register

    // Write decode
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg_q.t_clkgate        <= T_CLKGATE_RST;
            cfg_q.t_clkwake        <= T_CLKWAKE_RST;
            cfg_q.clkgate_disabled <= 1'b0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                REG_T_CLKGATE: cfg_q.t_clkgate        <= cfg_wdata[3:0];
                REG_T_CLKWAKE: cfg_q.t_clkwake        <= cfg_wdata[3:0];
                REG_CTRL:      cfg_q.clkgate_disabled <= cfg_wdata[0];
                default: ;                             // Unmapped, write dropped
            endcase
        end
    end

    // Read mux, unmapped addresses return zero
    always_comb begin
        case (cfg_addr)
            REG_T_CLKGATE: rd_mux = {4'd0, cfg_q.t_clkgate};
            REG_T_CLKWAKE: rd_mux = {4'd0, cfg_q.t_clkwake};
            REG_CTRL:      rd_mux = {7'd0, cfg_q.clkgate_disabled};
            default:       rd_mux = 8'd0;
        endcase
    end

    // Read data one cycle after the strobe
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= cfg_rd;
        end
    end

    always_ff @(posedge clock) begin
        if (cfg_rd) begin
            cfg_rdata <= rd_mux;
        end
    end

    assign cfg = cfg_q;  // Live config to the controller

endmodule

// ==== pgcbcg_ctrl.sv ====
// Clock-gate FSM with wake and idle timing, clock source handshake and visibility status

`timescale 1ns/1ps

module pgcbcg_ctrl
    import pgcbcg_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  cg_cfg_t    cfg,
    input  logic       activity,
    input  logic       pgcb_clkack,
    output logic       pgcb_clkreq,
    output logic       gclk_en,
    output cg_status_t status
);

    cg_state_e  state;
    cg_state_e  state_nxt;
    logic [3:0] timer;        // Wake count in WAKE_WAIT, idle count in UNGATED
    logic [3:0] timer_nxt;
    logic       clkreq_nxt;
    logic       gclk_en_nxt;
    logic       idle_hold;    // Keeps the idle timer loaded
    cg_status_t status_nxt;

    // Idle timer reloads on activity, and stays loaded while gating is off
    assign idle_hold = activity | cfg.clkgate_disabled;

    always_comb begin
        state_nxt   = state;
        timer_nxt   = timer;
        clkreq_nxt  = pgcb_clkreq;
        gclk_en_nxt = gclk_en;
        case (state)
            GATED: begin
                if (activity) begin
                    state_nxt  = CLK_REQ;
                    clkreq_nxt = 1'b1;  // Ask the clock source
                end
            end
            CLK_REQ: begin
                if (pgcb_clkack) begin
                    state_nxt = WAKE_WAIT;
                    timer_nxt = cfg.t_clkwake;
                end
            end
            WAKE_WAIT: begin
                if (timer == 4'd0) begin
                    state_nxt   = UNGATED;
                    gclk_en_nxt = 1'b1;
                    timer_nxt   = cfg.t_clkgate;
                end else begin
                    timer_nxt = timer - 4'd1;
                end
            end
            UNGATED: begin
                if (idle_hold) begin
                    timer_nxt = cfg.t_clkgate;
                end else if (timer == 4'd0) begin
                    // Idle time used up, gate and release on the same edge
                    state_nxt   = CLK_REL;
                    clkreq_nxt  = 1'b0;
                    gclk_en_nxt = 1'b0;
                end else begin
                    timer_nxt = timer - 4'd1;
                end
            end
            CLK_REL: begin
                // New activity waits until the release completes
                if (!pgcb_clkack) begin
                    state_nxt = GATED;
                    timer_nxt = 4'd0;
                end
            end
            default: begin
                state_nxt   = GATED;
                timer_nxt   = 4'd0;
                clkreq_nxt  = 1'b0;
                gclk_en_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= GATED;
            timer       <= 4'd0;
            pgcb_clkreq <= 1'b0;
            gclk_en     <= 1'b0;
        end else begin
            state       <= state_nxt;
            timer       <= timer_nxt;
            pgcb_clkreq <= clkreq_nxt;
            gclk_en     <= gclk_en_nxt;
        end
    end

    // Status built from next values so visa_bus lines up with the outputs
    always_comb begin
        status_nxt             = '0;
        status_nxt.state       = state_nxt;
        status_nxt.timer       = timer_nxt;
        status_nxt.activity    = activity;
        status_nxt.pgcb_clkreq = clkreq_nxt;
        status_nxt.gclk_en     = gclk_en_nxt;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            status <= '0;
        end else begin
            status <= status_nxt;
        end
    end

endmodule

// ==== pgcbcg_pkg.sv ====
// Shared types for the clock-gate controller: FSM states, register map, config and status

package pgcbcg_pkg;

    // Clock-gate FSM states, GATED must stay zero so visa_bus resets to all zeros
    typedef enum logic [2:0] {
        GATED     = 3'd0,  // Clock off, source released
        CLK_REQ   = 3'd1,  // Waiting for pgcb_clkack high
        WAKE_WAIT = 3'd2,  // Wake timer running
        UNGATED   = 3'd3,  // Clock enabled, idle timer running
        CLK_REL   = 3'd4   // Waiting for pgcb_clkack low
    } cg_state_e;

    // Configuration register map
    typedef enum logic [1:0] {
        REG_T_CLKGATE = 2'd0,  // Idle time before gating
        REG_T_CLKWAKE = 2'd1,  // Wake time after source ack
        REG_CTRL      = 2'd2   // Bit 0 is clkgate_disabled
    } cfg_addr_e;

    // Register reset values
    localparam logic [3:0] T_CLKGATE_RST = 4'd4;
    localparam logic [3:0] T_CLKWAKE_RST = 4'd2;

    // Configuration seen by the controller
    typedef struct packed {
        logic [3:0] t_clkgate;         // Idle cycles minus one
        logic [3:0] t_clkwake;         // Wake cycles
        logic       clkgate_disabled;  // Keeps the clock running
    } cg_cfg_t;

    // Visibility bus layout, 32 bits
    typedef struct packed {
        logic [21:0] rsvd;         // Always zero
        cg_state_e   state;        // FSM state
        logic [3:0]  timer;        // Shared wake/idle timer
        logic        activity;     // Aggregated request
        logic        pgcb_clkreq;  // Clock source request
        logic        gclk_en;      // Gated clock enable
    } cg_status_t;

endpackage

// ==== pgcbcg_top.sv ====
// Clock-gate controller top: config registers, CDC request aggregator and gating FSM

`timescale 1ns/1ps

module pgcbcg_top
    import pgcbcg_pkg::*;
#(
    parameter int ICDC            = 5,
    parameter int NGCLK_REQ_ASYNC = 5
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       cfg_wr,
    input  logic                       cfg_rd,
    input  cfg_addr_e                  cfg_addr,
    input  logic [7:0]                 cfg_wdata,
    output logic [7:0]                 cfg_rdata,
    output logic                       cfg_rvalid,
    input  logic [ICDC-1:0]            cdc_clkreq,
    input  logic [NGCLK_REQ_ASYNC-1:0] cdc_gclock_req_async,
    input  logic                       pgcb_clkack,
    output logic [ICDC-1:0]            cdc_clkack,
    output logic                       pgcb_clkreq,
    output logic                       gclk_en,
    output logic [31:0]                visa_bus
);

    cg_cfg_t    cfg;       // Live configuration
    logic       activity;  // Any agent requesting
    cg_status_t status;    // Controller visibility

    pgcbcg_cfg_regs u_cfg_regs (
        .clock      (clock),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid),
        .cfg        (cfg)
    );

    cdc_req_aggregator #(
        .ICDC            (ICDC),
        .NGCLK_REQ_ASYNC (NGCLK_REQ_ASYNC)
    ) u_req_aggr (
        .clock                (clock),
        .rst_n                (rst_n),
        .cdc_clkreq           (cdc_clkreq),
        .cdc_gclock_req_async (cdc_gclock_req_async),
        .clk_on               (gclk_en),  // Ack only with the clock running
        .cdc_clkack           (cdc_clkack),
        .activity             (activity)
    );

    pgcbcg_ctrl u_ctrl (
        .clock       (clock),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .activity    (activity),
        .pgcb_clkack (pgcb_clkack),
        .pgcb_clkreq (pgcb_clkreq),
        .gclk_en     (gclk_en),
        .status      (status)
    );

    assign visa_bus = status;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the clock-gate controller testbench with Verilator and runs it.
# Exit status is nonzero when the build, the run or the test fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_pgcbcg

verilator --binary --timing --assert --top-module "$TOP" -f pgcbcg.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0

// ==== tb_pgcbcg.sv ====
// Testbench for the clock-gate controller with a clock source model and table-driven checks

`timescale 1ns/1ps

module tb_pgcbcg
    import pgcbcg_pkg::*;
();

    localparam int ICDC       = 5;
    localparam int NASYNC     = 5;
    localparam int TIMEOUT    = 200;  // Cycles per wait
    localparam int SYNC_LAT   = 1;    // Sync clkreq to activity
    localparam int ASYNC_LAT  = 3;    // Async request to activity
    localparam int IDLE_CHECK = 40;   // Idle cycles watched with gating off
    localparam int STATE_LSB  = 7;    // visa_bus state field position
    localparam int NROWS      = 7;
    localparam int SEL_CLKREQ = 0;
    localparam int SEL_GCLK   = 1;
    localparam int SEL_GATED  = 2;

    typedef struct packed {
        logic [3:0] t_clkgate;
        logic [3:0] t_clkwake;
        logic       cg_dis;     // Gating disabled during the row
        logic       async_req;  // Request through an async bit
        logic [2:0] agent;
        logic [7:0] hold;       // Cycles the request stays up after wake
    } row_t;

    logic              clock = 1'b0;
    logic              rst_n;
    logic              cfg_wr;
    logic              cfg_rd;
    cfg_addr_e         cfg_addr;
    logic [7:0]        cfg_wdata;
    logic [7:0]        cfg_rdata;
    logic              cfg_rvalid;
    logic [ICDC-1:0]   cdc_clkreq;
    logic [NASYNC-1:0] cdc_gclock_req_async;
    logic              pgcb_clkack = 1'b0;
    logic [ICDC-1:0]   cdc_clkack;
    logic              pgcb_clkreq;
    logic              gclk_en;
    logic [31:0]       visa_bus;

    row_t rows [NROWS];
    int   cyc = 0;       // Posedges since time zero
    int   ack_edge = 0;  // First edge that samples pgcb_clkack high
    int   ack_left = 0;  // Clock source delay still to run
    int   test_err;
    int   test_num = 0;
    int   pass_cnt = 0;
    int   fail_cnt = 0;
    bit   abort = 1'b0;

    pgcbcg_top u_dut (
        .clock                (clock),
        .rst_n                (rst_n),
        .cfg_wr               (cfg_wr),
        .cfg_rd               (cfg_rd),
        .cfg_addr             (cfg_addr),
        .cfg_wdata            (cfg_wdata),
        .cfg_rdata            (cfg_rdata),
        .cfg_rvalid           (cfg_rvalid),
        .cdc_clkreq           (cdc_clkreq),
        .cdc_gclock_req_async (cdc_gclock_req_async),
        .pgcb_clkack          (pgcb_clkack),
        .cdc_clkack           (cdc_clkack),
        .pgcb_clkreq          (pgcb_clkreq),
        .gclk_en              (gclk_en),
        .visa_bus             (visa_bus)
    );

    always #10 clock = ~clock;

    always @(posedge clock) cyc <= cyc + 1;

    // Clock source follows pgcb_clkreq after 1 to 4 cycles
    always @(negedge clock) begin
        if (!rst_n) begin
            pgcb_clkack <= 1'b0;
            ack_left = 0;
        end else if (pgcb_clkreq != pgcb_clkack) begin
            if (ack_left == 0) begin
                ack_left = $urandom_range(4, 1);
            end
            ack_left = ack_left - 1;
            if (ack_left == 0) begin
                pgcb_clkack <= pgcb_clkreq;
                if (pgcb_clkreq) begin
                    ack_edge = cyc + 1;  // Next posedge sees the ack
                end
            end
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            test_err++;
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            SEL_CLKREQ: return pgcb_clkreq;
            SEL_GCLK:   return gclk_en;
            default:    return visa_bus[STATE_LSB +: 3] == 3'd0;  // State GATED
        endcase
    endfunction

    // Counts falling edges until the probed signal reaches val
    task automatic wait_sig(input int sel, input logic val, input string what,
                            output int n, output bit ok);
        ok = 1'b0;
        for (n = 1; n <= TIMEOUT; n++) begin
            @(negedge clock);
            if (probe(sel) == val) begin
                ok = 1'b1;
                break;
            end
        end
        assert (ok) else begin
            $display("timeout at %0t: %s not seen within %0d cycles", $time, what, TIMEOUT);
            test_err++;
            abort = 1'b1;
        end
    endtask

    task automatic write_reg(input cfg_addr_e addr, input logic [7:0] data);
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_wr    = 1'b1;
        @(negedge clock);
        cfg_wr    = 1'b0;
    endtask

    task automatic read_check(input cfg_addr_e addr, input logic [7:0] exp, input string name);
        cfg_addr = addr;
        cfg_rd   = 1'b1;
        @(negedge clock);
        cfg_rd   = 1'b0;
        check_eq({name, " cfg_rvalid"}, 32'(cfg_rvalid), 32'd1);
        check_eq({name, " cfg_rdata"}, 32'(cfg_rdata), 32'(exp));
        @(negedge clock);
        check_eq({name, " cfg_rvalid after read"}, 32'(cfg_rvalid), 32'd0);
    endtask

    task automatic drive_req(input row_t r, input logic on);
        if (r.async_req) begin
            cdc_gclock_req_async[r.agent] = on;
        end else begin
            cdc_clkreq[r.agent] = on;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (test_err == 0) begin
            pass_cnt++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", test_num, name, test_err);
        end
    endtask

    task automatic load_table();
        rows[0] = '{4'd4,  4'd2,  1'b0, 1'b0, 3'd0, 8'd3};
        rows[1] = '{4'd0,  4'd0,  1'b0, 1'b1, 3'd2, 8'd1};
        rows[2] = '{4'd7,  4'd5,  1'b0, 1'b0, 3'd4, 8'd6};
        rows[3] = '{4'd2,  4'd9,  1'b0, 1'b1, 3'd4, 8'd2};
        rows[4] = '{4'd15, 4'd1,  1'b0, 1'b0, 3'd3, 8'd5};
        rows[5] = '{4'd3,  4'd3,  1'b1, 1'b0, 3'd1, 8'd2};
        rows[6] = '{4'd1,  4'd15, 1'b1, 1'b1, 3'd0, 8'd4};
    endtask

    task automatic row_body(input row_t r);
        int              n;
        int              lat;
        bit              ok;
        logic [ICDC-1:0] ack_exp;
        cg_status_t      vis_exp;
        lat     = r.async_req ? ASYNC_LAT : SYNC_LAT;
        ack_exp = '0;
        if (!r.async_req) begin
            ack_exp[r.agent] = 1'b1;  // Async requests get no clkack
        end
        // Clock running with the idle timer held at its reload value
        vis_exp             = '0;
        vis_exp.state       = UNGATED;
        vis_exp.timer       = r.t_clkgate;
        vis_exp.activity    = 1'b1;
        vis_exp.pgcb_clkreq = 1'b1;
        vis_exp.gclk_en     = 1'b1;
        write_reg(REG_T_CLKGATE, {4'd0, r.t_clkgate});
        write_reg(REG_T_CLKWAKE, {4'd0, r.t_clkwake});
        write_reg(REG_CTRL, {7'd0, r.cg_dis});
        read_check(REG_T_CLKGATE, {4'd0, r.t_clkgate}, "t_clkgate");
        read_check(REG_T_CLKWAKE, {4'd0, r.t_clkwake}, "t_clkwake");
        read_check(REG_CTRL, {7'd0, r.cg_dis}, "ctrl");
        // Wake
        drive_req(r, 1'b1);
        wait_sig(SEL_CLKREQ, 1'b1, "pgcb_clkreq high", n, ok);
        if (!ok) return;
        check_eq("pgcb_clkreq rise delay", n, lat + 1);
        wait_sig(SEL_GCLK, 1'b1, "gclk_en high", n, ok);
        if (!ok) return;
        check_eq("gclk_en cycles after ack", cyc - ack_edge, r.t_clkwake + 1);
        repeat (r.hold) begin
            @(negedge clock);
            check_eq("cdc_clkack", 32'(cdc_clkack), 32'(ack_exp));
            check_eq("gclk_en held", 32'(gclk_en), 32'd1);
            check_eq("visa_bus while held", visa_bus, 32'(vis_exp));
        end
        // Idle gating
        drive_req(r, 1'b0);
        if (r.cg_dis) begin
            repeat (IDLE_CHECK) begin
                @(negedge clock);
                check_eq("gclk_en with gating off", 32'(gclk_en), 32'd1);
            end
            write_reg(REG_CTRL, 8'd0);
            wait_sig(SEL_CLKREQ, 1'b0, "pgcb_clkreq low", n, ok);
            if (!ok) return;
            check_eq("pgcb_clkreq fall after enable", n + 1, r.t_clkgate + 2);
        end else begin
            wait_sig(SEL_CLKREQ, 1'b0, "pgcb_clkreq low", n, ok);
            if (!ok) return;
            check_eq("pgcb_clkreq fall delay", n, lat + r.t_clkgate + 1);
        end
        check_eq("gclk_en at release", 32'(gclk_en), 32'd0);
        check_eq("cdc_clkack at release", 32'(cdc_clkack), 32'd0);
        wait_sig(SEL_GATED, 1'b1, "visa_bus state GATED", n, ok);
        if (!ok) return;
        check_eq("pgcb_clkack at GATED", 32'(pgcb_clkack), 32'd0);
        check_eq("visa_bus clkreq and gclk_en", 32'(visa_bus[1:0]), 32'd0);
    endtask

    task automatic run_row(input int idx);
        string name;
        row_t  r;
        r        = rows[idx];
        test_err = 0;
        name     = $sformatf("row %0d %s agent %0d%s", idx, r.async_req ? "async" : "sync",
                             r.agent, r.cg_dis ? " gating off" : "");
        row_body(r);
        end_test(name);
    endtask

    initial begin
        void'($urandom(44));
        rst_n                = 1'b0;
        cfg_wr               = 1'b0;
        cfg_rd               = 1'b0;
        cfg_addr             = REG_T_CLKGATE;
        cfg_wdata            = 8'd0;
        cdc_clkreq           = '0;
        cdc_gclock_req_async = '0;
        load_table();
        repeat (10) @(negedge clock);
        rst_n = 1'b1;

        test_err = 0;
        check_eq("pgcb_clkreq", 32'(pgcb_clkreq), 32'd0);
        check_eq("gclk_en", 32'(gclk_en), 32'd0);
        check_eq("cdc_clkack", 32'(cdc_clkack), 32'd0);
        check_eq("visa_bus", visa_bus, 32'd0);
        read_check(REG_T_CLKGATE, 8'd4, "t_clkgate");
        read_check(REG_T_CLKWAKE, 8'd2, "t_clkwake");
        read_check(REG_CTRL, 8'd0, "ctrl");
        read_check(cfg_addr_e'(2'd3), 8'd0, "unmapped");  // No register at address 3
        end_test("reset defaults");

        for (int i = 0; i < NROWS && !abort; i++) begin
            run_row(i);
        end

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
